// File: build.f
hw/ddc_pkg.sv
hw/phase_accumulator.sv
hw/cordic_rotator.sv
hw/cic_decimator.sv
hw/ddc_top.sv
verification/ddc_props.sv
verification/ddc_checker.sv
verification/ddc_tb.sv

// File: Makefile
# Verilator build and run for the receiver front end

VERILATOR ?= verilator
TOP       ?= ddc_tb
FLAGS     ?=
SEED      ?= 119083892
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(FLAGS) -GSEED=$(SEED) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f build.f

clean:
	rm -rf $(OBJ_DIR)

// File: verification/ddc_tb.sv
// testbench top for the receiver front end, drives the five stimulus phases and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module ddc_tb #(
   parameter int unsigned SEED = 32'h07191374
);
   import ddc_pkg::*;

   localparam int DECIM = 4;
   localparam int TIMEOUT_CYCLES = 5000;   // per stream run

   logic    clk;
   logic    rst;
   phase_t  freq;
   iq_in_t  in_data;
   logic    in_valid;
   logic    in_ready;
   cic_iq_t out_data;
   logic    out_valid;
   logic    out_ready;
   int      test_id;
   string   test_label;
   int      chk_errors;
   int      out_count;
   int      pending;
   int      tb_errors;
   int      timeouts;
   logic [31:0] lfsr_state;

   initial clk = 1'b0;
   always #10 clk = ~clk;   // 20 ns period

   ddc_top #(.DECIM(DECIM)) dut_i (
      .clk       (clk),
      .rst       (rst),
      .freq      (freq),
      .in_data   (in_data),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   ddc_checker #(.DECIM(DECIM)) checker_i (
      .clk       (clk),
      .rst       (rst),
      .freq      (freq),
      .in_data   (in_data),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .test_id   (test_id),
      .errors    (chk_errors),
      .out_count (out_count),
      .pending   (pending)
   );

   bind ddc_top ddc_props props_i (
      .clk       (clk),
      .rst       (rst),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int b = 0; b < n; b++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic iq_in_t random_sample();
      iq_in_t s;
      s.i = sample_t'(lfsr_bits(16));
      s.q = sample_t'(lfsr_bits(16));
      return s;
   endfunction

   // feed n inputs, optionally wait for every expected output
   task automatic run_stream(input int n, input bit rand_data, input iq_in_t const_data,
                             input bit gaps, input bit stalls, input bit drain);
      int sent;
      int guard;
      int start_count;
      bit offered;
      bit done;
      sent        = 0;
      guard       = 0;
      offered     = 1'b0;
      done        = 1'b0;
      start_count = out_count;
      while (!done && guard < TIMEOUT_CYCLES) begin
         @(negedge clk);
         guard++;
         if (sent >= n && (!drain || pending == 0)) begin
            done     = 1'b1;
            in_valid = 1'b0;
         end else begin
            out_ready = stalls ? (lfsr_bits(2) != 0) : 1'b1;   // stall 1 in 4
            if (!offered) begin
               if (sent < n && !(gaps && lfsr_bits(2) == 0)) begin
                  in_valid = 1'b1;
                  in_data  = rand_data ? random_sample() : const_data;
                  offered  = 1'b1;
               end else begin
                  in_valid = 1'b0;   // bubble
               end
            end
            @(posedge clk);
            if (in_valid && in_ready) begin
               sent++;
               offered = 1'b0;
            end
         end
      end
      if (!done) begin
         @(negedge clk);   // loop left on a rising edge
         timeouts++;
         in_valid = 1'b0;
         $display("timeout in %s with %0d of %0d inputs sent and %0d outputs pending",
                  test_label, sent, n, pending);
      end else if (drain && out_count - start_count != n / DECIM) begin
         tb_errors++;
         $display("CHECK FAILED %s output count expected %0d actual %0d",
                  test_label, n / DECIM, out_count - start_count);
      end
      out_ready = 1'b1;
   endtask

   task automatic pulse_reset();
      @(negedge clk);
      in_valid = 1'b0;
      rst      = 1'b1;
      repeat (2) @(negedge clk);
      rst = 1'b0;
   endtask

   initial begin
      iq_in_t cst;
      rst        = 1'b1;
      freq       = '0;
      in_data    = '0;
      in_valid   = 1'b0;
      out_ready  = 1'b1;
      test_id    = 0;
      test_label = "reset";
      tb_errors  = 0;
      timeouts   = 0;
      lfsr_state = SEED;
      cst.i      = 16'sd9000;
      cst.q      = -16'sd4000;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_id    = 1;
      test_label = "constant_zero_freq";
      run_stream(64, 1'b0, cst, 1'b0, 1'b0, 1'b1);

      test_id    = 2;
      test_label = "quadrant_rotation";
      for (int qd = 0; qd < 4; qd++) begin
         freq = {2'(qd), 18'(lfsr_bits(18))};   // big step lands in every quadrant
         run_stream(32, 1'b1, cst, 1'b0, 1'b0, 1'b1);
      end

      test_id    = 3;
      test_label = "input_gaps";
      freq       = 20'h0_3c5a;
      run_stream(48, 1'b1, cst, 1'b1, 1'b0, 1'b1);

      test_id    = 4;
      test_label = "output_stalls";
      freq       = 20'h5_1234;
      run_stream(48, 1'b1, cst, 1'b1, 1'b1, 1'b1);

      test_id    = 5;
      test_label = "midstream_reset";
      freq       = 20'h2_7777;
      run_stream(30, 1'b1, cst, 1'b0, 1'b0, 1'b0);   // leave items in flight
      pulse_reset();
      run_stream(40, 1'b1, cst, 1'b1, 1'b1, 1'b1);

      repeat (4) @(negedge clk);
      $display("errors: checker=%0d testbench=%0d timeouts=%0d outputs=%0d",
               chk_errors, tb_errors, timeouts, out_count);
      if (chk_errors == 0 && tb_errors == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/ddc_checker.sv
// scoreboard beside the DUT, models NCO, CORDIC and CIC bit-exactly and compares each output transfer
`timescale 1ns/1ps
`default_nettype none

module ddc_checker #(
   parameter int DECIM = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  ddc_pkg::phase_t  freq,
   input  ddc_pkg::iq_in_t  in_data,
   input  logic             in_valid,
   input  logic             in_ready,
   input  ddc_pkg::cic_iq_t out_data,
   input  logic             out_valid,
   input  logic             out_ready,
   input  int               test_id,
   output int               errors,      // value mismatches and extra outputs
   output int               out_count,   // output transfers seen
   output int               pending      // expected outputs not yet seen
);
   import ddc_pkg::*;

   phase_t  ref_phase;       // model NCO
   cic_t    integ [2][3];    // model integrators, 0 is I
   cic_t    dly [2][3];      // model comb delays
   int      blk_cnt;         // inputs in current block
   cic_iq_t exp_q [$];       // expected outputs in order

   function automatic string test_name(input int id);
      case (id)
         1: return "constant_zero_freq";
         2: return "quadrant_rotation";
         3: return "input_gaps";
         4: return "output_stalls";
         5: return "midstream_reset";
         default: return "idle";
      endcase
   endfunction

   // quadrant fold, then 15 micro-rotations, keep bits 19..2
   function automatic rot_iq_t cordic_ref(input iq_in_t d, input phase_t p);
      logic signed [19:0] x;
      logic signed [19:0] y;
      logic signed [19:0] xs;
      logic signed [19:0] ys;
      int      a;   // residual angle, never narrowed
      rot_iq_t r;
      x = {d.i[15], d.i, 3'b000};
      y = {d.q[15], d.q, 3'b000};
      if (p[19] != p[18]) begin   // 180 degree turn
         x = -x;
         y = -y;
      end
      a = int'(p[18:0]);
      if (p[18]) begin
         a = a - (1 << 19);   // lower 19 bits as signed, +-90 deg
      end
      for (int k = 0; k < CORDIC_STAGES; k++) begin
         xs = x >>> k;
         ys = y >>> k;
         if (a < 0) begin   // residual negative, turn clockwise
            x = x + ys;
            y = y - xs;
            a = a + ATAN_TABLE[k];
         end else begin
            x = x - ys;
            y = y + xs;
            a = a - ATAN_TABLE[k];
         end
      end
      r.i = x[19:2];
      r.q = y[19:2];
      return r;
   endfunction

   task automatic model_input(input iq_in_t d);
      rot_iq_t r;
      cic_t    x [2];
      cic_t    c [4];
      cic_iq_t o;
      r = cordic_ref(d, ref_phase);
      ref_phase = ref_phase + freq;   // k-th sample saw k*freq
      x[0] = cic_t'(r.i);
      x[1] = cic_t'(r.q);
      for (int ch = 0; ch < 2; ch++) begin
         integ[ch][2] = integ[ch][2] + integ[ch][1];   // old values first
         integ[ch][1] = integ[ch][1] + integ[ch][0];
         integ[ch][0] = integ[ch][0] + x[ch];
      end
      blk_cnt++;
      if (blk_cnt == DECIM) begin
         blk_cnt = 0;
         for (int ch = 0; ch < 2; ch++) begin
            c[0] = integ[ch][2];
            for (int s = 0; s < 3; s++) c[s+1] = c[s] - dly[ch][s];
            for (int s = 0; s < 3; s++) dly[ch][s] = c[s];
            if (ch == 0) o.i = c[3];
            else o.q = c[3];
         end
         exp_q.push_back(o);
      end
   endtask

   initial begin
      errors    = 0;
      out_count = 0;
      pending   = 0;
   end

   always @(posedge clk) begin
      cic_iq_t e;
      if (rst) begin   // model follows DUT reset
         ref_phase = '0;
         blk_cnt   = 0;
         exp_q.delete();
         for (int ch = 0; ch < 2; ch++) begin
            for (int s = 0; s < 3; s++) begin
               integ[ch][s] = '0;
               dly[ch][s]   = '0;
            end
         end
      end else begin
         if (in_valid && in_ready) model_input(in_data);
         if (out_valid && out_ready) begin
            out_count++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("output transfer in %s with no output expected", test_name(test_id));
            end else begin
               e = exp_q.pop_front();
               if (out_data !== e) begin
                  errors++;
                  $display("CHECK FAILED %s expected i=%0d q=%0d actual i=%0d q=%0d",
                           test_name(test_id), e.i, e.q, out_data.i, out_data.q);
               end
            end
         end
      end
      pending = exp_q.size();
   end

endmodule

`default_nettype wire

// File: verification/ddc_props.sv
// handshake and reset assertions for the receiver front end, attached to ddc_top by bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module ddc_props (
   input logic             clk,
   input logic             rst,
   input logic             in_ready,
   input logic             out_valid,
   input logic             out_ready,
   input ddc_pkg::cic_iq_t out_data
);

   // stalled output holds valid and payload
   out_stable_a: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("output payload changed while stalled");

   // synchronous reset empties the holding register
   reset_clear_a: assert property (@(posedge clk) rst |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

   // input side only blocked by output back-pressure
   ready_rule_a: assert property (@(posedge clk)
      in_ready == !(out_valid && !out_ready))
      else $error("in_ready does not follow output back-pressure");

endmodule

`default_nettype wire

// File: hw/ddc_top.sv
// receiver mixing and decimation front end, NCO then CORDIC rotator then CIC, one shared stall
`timescale 1ns/1ps
`default_nettype none

module ddc_top #(
   parameter int DECIM = 4   // CIC ratio, 2 or 4
) (
   input  logic             clk,
   input  logic             rst,
   input  ddc_pkg::phase_t  freq,        // quasi-static tuning word
   input  ddc_pkg::iq_in_t  in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output ddc_pkg::cic_iq_t out_data,
   output logic             out_valid,
   input  logic             out_ready
);
   import ddc_pkg::*;

   logic    advance;     // whole pipeline steps
   logic    smp_valid;
   iq_in_t  smp_data;
   phase_t  smp_phase;
   logic    rot_valid;
   rot_iq_t rot_data;

   assign in_ready = advance;   // input accepted only when everything moves

   phase_accumulator nco_i (
      .clk       (clk),
      .rst       (rst),
      .advance   (advance),
      .freq      (freq),
      .in_data   (in_data),
      .in_valid  (in_valid),
      .smp_data  (smp_data),
      .smp_phase (smp_phase),
      .smp_valid (smp_valid)
   );

   // 17 advance cycles deep
   cordic_rotator rot_i (
      .clk       (clk),
      .rst       (rst),
      .advance   (advance),
      .in_valid  (smp_valid),
      .in_data   (smp_data),
      .in_phase  (smp_phase),
      .out_valid (rot_valid),
      .out_data  (rot_data)
   );

   cic_decimator #(
      .DECIM (DECIM)
   ) cic_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (rot_valid),
      .in_data   (rot_data),
      .ready     (advance),     // low only on output back-pressure
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

// File: hw/cic_decimator.sv
// three-stage CIC decimator for the rotated I/Q stream with an output holding register
`timescale 1ns/1ps
`default_nettype none

module cic_decimator #(
   parameter int DECIM = 4   // 2 or 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_valid,
   input  ddc_pkg::rot_iq_t in_data,
   output logic             ready,       // pipeline advance
   output logic             out_valid,
   output ddc_pkg::cic_iq_t out_data,
   input  logic             out_ready
);
   import ddc_pkg::*;

   localparam int CW = $clog2(DECIM);

   logic [CW-1:0] cnt;        // integrated samples in this block
   logic          dec_tick;   // last integration closed a block
   logic          take;
   cic_t x [2];               // sign extended input, 0 is I
   cic_t integ [2][3];        // integrators, wrap mod 2^24
   cic_t dly [2][3];          // comb delays
   cic_t comb [2][4];         // comb chain taps

   // holding register full and not taken
   assign ready = !out_valid || out_ready;
   assign take  = in_valid && ready;

   always_comb begin
      x[0] = {{6{in_data.i[17]}}, in_data.i};
      x[1] = {{6{in_data.q[17]}}, in_data.q};
      for (int c = 0; c < 2; c++) begin
         comb[c][0] = integ[c][2];
         for (int s = 0; s < 3; s++) begin
            comb[c][s+1] = comb[c][s] - dly[c][s];   // differential delay 1
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt       <= '0;
         dec_tick  <= 1'b0;
         out_valid <= 1'b0;
         for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < 3; s++) begin
               integ[c][s] <= '0;
               dly[c][s]   <= '0;
            end
         end
      end else begin
         // input rate
         if (take) begin
            for (int c = 0; c < 2; c++) begin
               integ[c][0] <= integ[c][0] + x[c];
               integ[c][1] <= integ[c][1] + integ[c][0];   // previous value
               integ[c][2] <= integ[c][2] + integ[c][1];
            end
            if (cnt == CW'(DECIM - 1)) begin
               cnt <= '0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
         dec_tick <= take && (cnt == CW'(DECIM - 1));
         // output rate
         if (dec_tick) begin
            for (int c = 0; c < 2; c++) begin
               for (int s = 0; s < 3; s++) begin
                  dly[c][s] <= comb[c][s];
               end
            end
         end
         // register always empty when a tick lands
         if (dec_tick) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   // holding register payload
   always_ff @(posedge clk) begin
      if (dec_tick) begin
         out_data.i <= comb[0][3];
         out_data.q <= comb[1][3];
      end
   end

endmodule

`default_nettype wire

// File: hw/cordic_rotator.sv
// pipelined CORDIC vector rotator with per-stage valid bits, all stages held while advance is low
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator (
   input  logic             clk,
   input  logic             rst,
   input  logic             advance,    // common stage enable
   input  logic             in_valid,
   input  ddc_pkg::iq_in_t  in_data,
   input  ddc_pkg::phase_t  in_phase,   // rotation angle
   output logic             out_valid,
   output ddc_pkg::rot_iq_t out_data
);
   import ddc_pkg::*;

   // 1 guard bit, 16 data bits, 3 fraction bits
   typedef logic signed [19:0] work_t;

   // width of the residual angle held after stage k
   function automatic int ang_width(input int k);
      if (k == 0) begin
         return 19;
      end else if (k == 1) begin
         return 18;
      end
      return 20 - k;
   endfunction

   // sign extend and append fraction bits
   function automatic work_t ext(input sample_t s);
      return {s[15], s, 3'b000};
   endfunction

   work_t  xi [0:CORDIC_STAGES];    // I per stage
   work_t  xq [0:CORDIC_STAGES];    // Q per stage
   phase_t ang [0:CORDIC_STAGES-1];   // residual angle, zero above its width
   phase_t ang_nxt [1:CORDIC_STAGES-1];
   work_t  i_sh [0:CORDIC_STAGES-1];
   work_t  q_sh [0:CORDIC_STAGES-1];
   logic   [CORDIC_STAGES-1:0] cw;     // residual negative
   logic   [CORDIC_STAGES:0]   vld;    // stage 0 to stage 15 valid
   logic   flip;                        // 2nd or 3rd quadrant

   // quadrants 01 and 10 need the extra 180 degree turn
   assign flip = in_phase[19] ^ in_phase[18];

   always_comb begin
      for (int k = 0; k < CORDIC_STAGES; k++) begin
         cw[k]   = ang[k][ang_width(k) - 1];   // top bit of narrowed residual
         i_sh[k] = xi[k] >>> k;                // arithmetic shift
         q_sh[k] = xq[k] >>> k;
      end
      for (int k = 1; k < CORDIC_STAGES; k++) begin
         if (cw[k-1]) begin
            ang_nxt[k] = ang[k-1] + phase_t'(ATAN_TABLE[k-1]);
         end else begin
            ang_nxt[k] = ang[k-1] - phase_t'(ATAN_TABLE[k-1]);
         end
         // drop the bits that can no longer be reached
         ang_nxt[k] = ang_nxt[k] & phase_t'((1 << ang_width(k)) - 1);
      end
   end

   // valid chain, the only state reset touches
   always_ff @(posedge clk) begin
      if (rst) begin
         vld       <= '0;
         out_valid <= 1'b0;
      end else if (advance) begin
         vld       <= {vld[CORDIC_STAGES-1:0], in_valid};
         out_valid <= vld[CORDIC_STAGES];   // 17th advance
      end
   end

   // data path
   always_ff @(posedge clk) begin
      if (advance) begin
         // stage 0 pre-rotation
         ang[0] <= {1'b0, in_phase[18:0]};   // angle left inside +-90 deg
         if (flip) begin
            xi[0] <= -ext(in_data.i);
            xq[0] <= -ext(in_data.q);
         end else begin
            xi[0] <= ext(in_data.i);
            xq[0] <= ext(in_data.q);
         end
         // micro-rotations 1 to 15
         for (int k = 0; k < CORDIC_STAGES; k++) begin
            if (cw[k]) begin
               xi[k+1] <= xi[k] + q_sh[k];
               xq[k+1] <= xq[k] - i_sh[k];
            end else begin
               xi[k+1] <= xi[k] - q_sh[k];
               xq[k+1] <= xq[k] + i_sh[k];
            end
         end
         for (int k = 1; k < CORDIC_STAGES; k++) begin
            ang[k] <= ang_nxt[k];   // last residual never needed
         end
         // truncate to 18 bits
         out_data.i <= xi[CORDIC_STAGES][19:2];
         out_data.q <= xq[CORDIC_STAGES][19:2];
      end
   end

endmodule

`default_nettype wire

// File: hw/phase_accumulator.sv
// NCO stage that tags each accepted input sample with the running phase before the rotator
`timescale 1ns/1ps
`default_nettype none

module phase_accumulator (
   input  logic             clk,
   input  logic             rst,
   input  logic             advance,     // pipeline moves this cycle
   input  ddc_pkg::phase_t  freq,        // phase step per sample
   input  ddc_pkg::iq_in_t  in_data,
   input  logic             in_valid,
   output ddc_pkg::iq_in_t  smp_data,
   output ddc_pkg::phase_t  smp_phase,
   output logic             smp_valid
);
   import ddc_pkg::*;

   phase_t phase;   // running accumulator
   logic   take;    // input transfer

   assign take = advance && in_valid;

   // control state
   always_ff @(posedge clk) begin
      if (rst) begin
         phase     <= '0;
         smp_valid <= 1'b0;
      end else if (advance) begin
         smp_valid <= in_valid;   // bubble when no input
         if (take) begin
            phase <= phase + freq;   // wraps mod 2pi
         end
      end
   end

   // sample paired with phase before the step
   always_ff @(posedge clk) begin
      if (take) begin
         smp_data  <= in_data;
         smp_phase <= phase;   // k-th sample sees k*freq
      end
   end

endmodule

`default_nettype wire

// File: hw/ddc_pkg.sv
// shared widths, stream structs and CORDIC angle table of the receiver front end, imported by each stage
`default_nettype none

package ddc_pkg;

   typedef logic signed [15:0] sample_t;   // input I or Q
   typedef logic        [19:0] phase_t;    // 2^19 is pi rad
   typedef logic signed [17:0] rot_t;      // rotator output component
   typedef logic signed [23:0] cic_t;      // 18 bits plus growth for decim 4

   // input sample pair
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_in_t;

   typedef struct packed {
      rot_t i;
      rot_t q;
   } rot_iq_t;   // after mixing

   typedef struct packed {
      cic_t i;
      cic_t q;
   } cic_iq_t;   // decimated output

   localparam int CORDIC_STAGES = 15;   // micro-rotations kept

   // atan(2^-k) in units where 45 degrees is 2^17
   localparam int ATAN_TABLE [CORDIC_STAGES] = '{
      131072, 77376, 40884, 20753, 10417,
      5213, 2607, 1304, 652, 326,
      163, 81, 41, 20, 10
   };

endpackage

`default_nettype wire
